//--- rtl/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

	// word widths
	localparam int NB_WORD    = 32;           // data and instruction width
	localparam int NB_HALF    = NB_WORD / 2;  // half-word carried per command
	localparam int NB_LATCH   = 2 * NB_WORD;  // IF/ID latch, {instr, pc}
	localparam int NB_BIT_CNT = $clog2(NB_WORD); // spi bit counter

	// instruction ram
	localparam int RAM_DEPTH_LOG = 10;                  // word address bits
	localparam int RAM_DEPTH     = 1 << RAM_DEPTH_LOG;  // 1024 words
	localparam int PC_ADDR_LO    = 2;                   // byte pc to word index

	// command word layout
	localparam int CMD_WE_BIT = 22; // memory write request
	localparam int CMD_OP_HI  = 20; // register operation field
	localparam int CMD_OP_LO  = 19;
	localparam int CMD_SEL_HI = 17; // readback selector
	localparam int CMD_SEL_LO = 16;

	// register operation codes
	localparam logic [1:0] OP_NONE    = 2'b00;
	localparam logic [1:0] OP_DATA_LO = 2'b01; // lower half of data word
	localparam logic [1:0] OP_DATA_HI = 2'b10; // upper half of data word
	localparam logic [1:0] OP_ADDR    = 2'b11; // debug ram address

	// readback codes, 2'b11 returns zero
	localparam logic [1:0] SEL_PC          = 2'b00;
	localparam logic [1:0] SEL_LATCH_PC    = 2'b01;
	localparam logic [1:0] SEL_LATCH_INSTR = 2'b10;

	// fetch
	localparam logic [NB_WORD-1:0] PC_STEP = 32'd4; // byte step per run cycle

endpackage

`default_nettype wire

//--- rtl/ram_port_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ram_port_if import dbg_pkg::*; ();

	logic [RAM_DEPTH_LOG-1:0] addr;  // word address
	logic [NB_WORD-1:0]       wdata; // write data
	logic                     we;    // write enable
	logic [NB_WORD-1:0]       rdata; // read data, one cycle after addr

	// debug side, owns address and write
	modport ctrl (
		output addr,
		output wdata,
		output we
	);

	// the memory itself
	modport mem (
		input  addr,
		input  wdata,
		input  we,
		output rdata
	);

	modport mon (input rdata); // fetch only looks at read data

endinterface

`default_nettype wire

//--- rtl/spi_slave.sv
`timescale 1ns/10ps
`default_nettype none

module spi_slave import dbg_pkg::*; (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_sclk,
	input  logic               i_cs_n,
	input  logic               i_mosi,
	output logic               o_miso,
	output logic [NB_WORD-1:0] o_cmd,     // last complete command, held
	output logic               o_cmd_stb, // one cycle per complete frame
	input  logic [NB_WORD-1:0] i_reply    // word shifted out next frame
);

	logic [2:0]            sclk_pipe; // [1] synced, [2] previous
	logic [2:0]            cs_pipe;
	logic [1:0]            mosi_pipe;
	logic                  sclk_s;
	logic                  sclk_d;
	logic                  cs_s;
	logic                  cs_d;
	logic                  mosi_s;
	logic                  sclk_rise;
	logic                  sclk_fall;
	logic                  cs_fall;
	logic                  active;
	logic [NB_BIT_CNT-1:0] bit_cnt;
	logic [NB_WORD-1:0]    rx_shift;
	logic [NB_WORD-1:0]    tx_shift;
	logic [NB_WORD-1:0]    rx_next;

	// two-flop synchronisers plus one stage for edge detect
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			sclk_pipe <= 3'b000; // mode 0 idles low
			cs_pipe   <= 3'b111; // deselected
			mosi_pipe <= 2'b00;
		end else begin
			sclk_pipe <= {sclk_pipe[1:0], i_sclk};
			cs_pipe   <= {cs_pipe[1:0], i_cs_n};
			mosi_pipe <= {mosi_pipe[0], i_mosi};
		end
	end

	assign sclk_s = sclk_pipe[1];
	assign sclk_d = sclk_pipe[2];
	assign cs_s   = cs_pipe[1];
	assign cs_d   = cs_pipe[2];
	assign mosi_s = mosi_pipe[1]; // same delay as sclk_s

	assign sclk_rise = sclk_s & ~sclk_d;
	assign sclk_fall = ~sclk_s & sclk_d;
	assign cs_fall   = ~cs_s & cs_d;
	assign active    = ~cs_s;

	assign rx_next = {rx_shift[NB_WORD-2:0], mosi_s}; // msb first

	// receive side
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			bit_cnt   <= '0;
			rx_shift  <= '0;
			o_cmd     <= '0;
			o_cmd_stb <= 1'b0;
		end else begin
			o_cmd_stb <= 1'b0; // default, pulse only
			if (!active) begin
				bit_cnt <= '0; // partial frame dropped here
			end else if (sclk_rise) begin
				rx_shift <= rx_next;
				bit_cnt  <= bit_cnt + 1'b1; // wraps after last bit
				if (bit_cnt == NB_BIT_CNT'(NB_WORD - 1)) begin
					o_cmd     <= rx_next; // full word in
					o_cmd_stb <= 1'b1;
				end
			end
		end
	end

	// transmit side, msb presented before first rising sclk
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			tx_shift <= '0;
		end else if (cs_fall) begin
			tx_shift <= i_reply; // snapshot of reply at frame start
		end else if (active && sclk_fall) begin
			tx_shift <= {tx_shift[NB_WORD-2:0], 1'b0}; // next bit out
		end
	end

	assign o_miso = tx_shift[NB_WORD-1];

endmodule

`default_nettype wire

//--- rtl/debug_fetch_if.sv
`timescale 1ns/10ps
`default_nettype none

module debug_fetch_if import dbg_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rst,
	input  logic [NB_WORD-1:0]  i_cmd,     // held command word
	input  logic                i_cmd_stb, // new command this cycle
	input  logic                i_in_use,  // debug mode
	input  logic [NB_WORD-1:0]  i_pc,
	input  logic [NB_LATCH-1:0] i_latch,   // {instr, pc}
	output logic [NB_WORD-1:0]  o_reply,   // to spi shift-out
	ram_port_if.ctrl            ram
);

	logic [NB_WORD-1:0]       data_q; // assembled write data
	logic [RAM_DEPTH_LOG-1:0] addr_q; // debug ram address
	logic [1:0]               sel_q;  // readback selector
	logic [1:0]               op;

	assign op = i_cmd[CMD_OP_HI:CMD_OP_LO];

	// field operations, one per received frame
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			data_q <= '0;
			addr_q <= '0;
			sel_q  <= SEL_PC;
		end else if (i_cmd_stb) begin
			sel_q <= i_cmd[CMD_SEL_HI:CMD_SEL_LO]; // kept until next command
			case (op)
				OP_NONE:    ; // write-only or readback frame
				OP_DATA_LO: data_q[NB_HALF-1:0]       <= i_cmd[NB_HALF-1:0];
				OP_DATA_HI: data_q[NB_WORD-1:NB_HALF] <= i_cmd[NB_HALF-1:0];
				OP_ADDR:    addr_q <= i_cmd[RAM_DEPTH_LOG-1:0];
				default:    ;
			endcase
		end
	end

	// write sees the registers before this frame's update
	assign ram.we    = i_cmd_stb & i_in_use & i_cmd[CMD_WE_BIT];
	assign ram.wdata = data_q;

	// debug address while halted, else pc word index
	assign ram.addr = i_in_use ? addr_q
		: i_pc[RAM_DEPTH_LOG+PC_ADDR_LO-1:PC_ADDR_LO];

	// readback mux
	always_comb begin
		case (sel_q)
			SEL_PC:          o_reply = i_pc;
			SEL_LATCH_PC:    o_reply = i_latch[NB_WORD-1:0];
			SEL_LATCH_INSTR: o_reply = i_latch[NB_LATCH-1:NB_WORD];
			default:         o_reply = '0; // unused code reads zero
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/instr_ram.sv
`timescale 1ns/10ps
`default_nettype none

module instr_ram import dbg_pkg::*; (
	input  logic    i_clk,
	ram_port_if.mem ram
);

	logic [NB_WORD-1:0] mem [RAM_DEPTH]; // contents undefined until loaded

	// single port, write and registered read on the same edge
	always_ff @(posedge i_clk) begin
		if (ram.we) begin
			mem[ram.addr] <= ram.wdata;
		end
		ram.rdata <= mem[ram.addr]; // read-first on a write cycle
	end

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import dbg_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rst,
	input  logic                i_in_use, // halt pc and latch
	ram_port_if.mon             ram,
	output logic [NB_WORD-1:0]  o_pc,
	output logic [NB_LATCH-1:0] o_latch   // {instr, pc}
);

	logic [NB_WORD-1:0]  pc_q;
	logic [NB_WORD-1:0]  pc_prev; // pc that addressed current rdata
	logic                run_d;   // ran last cycle too
	logic [NB_LATCH-1:0] latch_q;
	logic                capture;

	// program counter
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pc_q <= '0;
		end else if (!i_in_use) begin
			pc_q <= pc_q + PC_STEP;
		end
	end

	always_ff @(posedge i_clk) begin
		pc_prev <= pc_q; // follows ram read latency
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			run_d <= 1'b0;
		end else begin
			run_d <= ~i_in_use;
		end
	end

	// first run cycle still reads the debug address
	assign capture = ~i_in_use & run_d;

	// IF/ID latch
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			latch_q <= '0;
		end else if (capture) begin
			latch_q <= {ram.rdata, pc_prev};
		end
	end

	assign o_pc    = pc_q;
	assign o_latch = latch_q;

endmodule

`default_nettype wire

//--- rtl/debug_fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module debug_fetch_top import dbg_pkg::*; (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_in_use,      // debug mode from the mcu
	input  logic               i_sclk,
	input  logic               i_cs_n,
	input  logic               i_mosi,
	output logic               o_miso,
	output logic [NB_WORD-1:0] o_pc,
	output logic [NB_WORD-1:0] o_latch_pc,
	output logic [NB_WORD-1:0] o_latch_instr
);

	logic [NB_WORD-1:0]  cmd;
	logic                cmd_stb;
	logic [NB_WORD-1:0]  reply;
	logic [NB_WORD-1:0]  pc;
	logic [NB_LATCH-1:0] latch;

	ram_port_if ram_bus ();

	// command link to the mcu
	spi_slave u_spi_slave (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_sclk    (i_sclk),
		.i_cs_n    (i_cs_n),
		.i_mosi    (i_mosi),
		.o_miso    (o_miso),
		.o_cmd     (cmd),
		.o_cmd_stb (cmd_stb),
		.i_reply   (reply)
	);

	// decode, debug registers, address mux
	debug_fetch_if u_debug_fetch_if (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_cmd     (cmd),
		.i_cmd_stb (cmd_stb),
		.i_in_use  (i_in_use),
		.i_pc      (pc),
		.i_latch   (latch),
		.o_reply   (reply),
		.ram       (ram_bus.ctrl)
	);

	instr_ram u_instr_ram (
		.i_clk (i_clk),
		.ram   (ram_bus.mem)
	);

	// pc and IF/ID latch
	fetch_stage u_fetch_stage (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_in_use (i_in_use),
		.ram      (ram_bus.mon),
		.o_pc     (pc),
		.o_latch  (latch)
	);

	assign o_pc          = pc;
	assign o_latch_pc    = latch[NB_WORD-1:0];        // lower half
	assign o_latch_instr = latch[NB_LATCH-1:NB_WORD]; // upper half

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic o_clk,
	output logic o_rst
);

	localparam int HALF_PERIOD = 2; // 4 ns clock
	localparam int RST_CYCLES  = 8;

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// synchronous reset, released on a rising edge
	initial begin
		o_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/debug_fetch_props.sv
`timescale 1ns/10ps
`default_nettype none

module debug_fetch_props import dbg_pkg::*; (
	input logic               i_clk,
	input logic               i_rst,
	input logic               i_in_use,
	input logic               i_we,      // ram write enable
	input logic               i_cmd_stb, // spi frame strobe
	input logic [NB_WORD-1:0] i_pc
);

	int unsigned err_cnt = 0; // fired assertions, polled by the testbench

	// writes only while halted
	no_run_write: assert property (@(posedge i_clk) disable iff (i_rst)
		!i_in_use |-> !i_we)
	else begin
		err_cnt++;
		$error("ram write while the core is running");
	end

	// strobe is a single pulse
	stb_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
		i_cmd_stb |=> !i_cmd_stb)
	else begin
		err_cnt++;
		$error("command strobe longer than one cycle");
	end

	pc_frozen: assert property (@(posedge i_clk) disable iff (i_rst)
		i_in_use |=> $stable(i_pc))
	else begin
		err_cnt++;
		$error("pc moved in debug mode");
	end

endmodule

`default_nettype wire

//--- tests/tb_debug_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module tb_debug_fetch import dbg_pkg::*; ();

	localparam int          SCLK_HALF   = 8;   // i_clk cycles per sclk phase
	localparam int          LOAD_WORDS  = 16;
	localparam int          RUN_CHECKS  = 20;
	localparam int          HALT_CYCLES = 50;
	localparam int          WAIT_LIMIT  = 200; // cycles before a wait gives up
	localparam logic [31:0] SEED        = 32'h6b47_7e49;

	logic               clk;
	logic               rst;
	logic               in_use;
	logic               sclk;
	logic               cs_n;
	logic               mosi;
	logic               miso;
	logic [NB_WORD-1:0] pc;
	logic [NB_WORD-1:0] latch_pc;
	logic [NB_WORD-1:0] latch_instr;

	logic [NB_WORD-1:0] model_mem   [RAM_DEPTH]; // words loaded over spi
	logic               model_valid [RAM_DEPTH];

	tb_clock u_tb_clock (
		.o_clk (clk),
		.o_rst (rst)
	);

	debug_fetch_top dut0 (
		.i_clk         (clk),
		.i_rst         (rst),
		.i_in_use      (in_use),
		.i_sclk        (sclk),
		.i_cs_n        (cs_n),
		.i_mosi        (mosi),
		.o_miso        (miso),
		.o_pc          (pc),
		.o_latch_pc    (latch_pc),
		.o_latch_instr (latch_instr)
	);

	bind debug_fetch_top debug_fetch_props props0 (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_in_use  (i_in_use),
		.i_we      (ram_bus.we),
		.i_cmd_stb (cmd_stb),
		.i_pc      (pc)
	);

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [NB_WORD-1:0] exp,
		input logic [NB_WORD-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			fail_run("value mismatch");
		end
	endtask

	// assertion hits end the run like any other check
	always @(negedge clk) begin
		if (dut0.props0.err_cnt != 0) begin
			fail_run("an assertion on the DUT fired");
		end
	end

	function automatic logic [NB_WORD-1:0] make_cmd(input logic we, input logic [1:0] op,
		input logic [1:0] sel, input logic [NB_HALF-1:0] payload);
		logic [NB_WORD-1:0] cmd;
		cmd                        = '0;
		cmd[CMD_WE_BIT]            = we;
		cmd[CMD_OP_HI:CMD_OP_LO]   = op;
		cmd[CMD_SEL_HI:CMD_SEL_LO] = sel;
		cmd[NB_HALF-1:0]           = payload; // half-word or address
		return cmd;
	endfunction

	// one mode 0 frame, msb first, sclk period 16 clocks
	task automatic spi_frame(input logic [NB_WORD-1:0] tx, output logic [NB_WORD-1:0] rx);
		logic [NB_WORD-1:0] tx_sr;
		tx_sr = tx;
		rx    = '0;
		@(posedge clk);
		cs_n <= 1'b0;
		mosi <= tx_sr[NB_WORD-1];
		repeat (SCLK_HALF) @(posedge clk); // slave loads its reply
		for (int i = 0; i < NB_WORD; i++) begin
			@(negedge clk);
			rx = {rx[NB_WORD-2:0], miso}; // stable since last falling sclk
			@(posedge clk);
			sclk <= 1'b1;
			repeat (SCLK_HALF) @(posedge clk);
			tx_sr = {tx_sr[NB_WORD-2:0], 1'b0};
			sclk <= 1'b0;
			mosi <= tx_sr[NB_WORD-1]; // next bit on falling edge
			repeat (SCLK_HALF - 1) @(posedge clk);
		end
		@(posedge clk);
		cs_n <= 1'b1;
		repeat (SCLK_HALF) @(posedge clk); // gap between frames
	endtask

	task automatic reset_state();
		logic [NB_WORD-1:0] reply;
		int                 wait_cnt;
		wait_cnt = 0;
		while (rst) begin
			@(posedge clk);
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT) begin
				fail_run("reset was never released");
			end
		end
		@(negedge clk);
		check_value("reset pc", '0, pc);
		check_value("reset latch pc", '0, latch_pc);
		check_value("reset latch instr", '0, latch_instr);
		check_value("reset miso", '0, {31'd0, miso});
		spi_frame(make_cmd(1'b0, OP_NONE, SEL_PC, '0), reply);
		check_value("reset first reply", '0, reply);
	endtask

	// pc is frozen at zero, so every reply here reads zero
	task automatic load_frame(input logic [NB_WORD-1:0] cmd);
		logic [NB_WORD-1:0] reply;
		spi_frame(cmd, reply);
		check_value("debug load reply", '0, reply);
	endtask

	task automatic debug_load();
		logic [NB_WORD-1:0] word;
		for (int k = 0; k < LOAD_WORDS; k++) begin
			word = $urandom();
			if (word == '0) begin
				word = 32'h1; // first capture is seen as a change of the instr
			end
			load_frame(make_cmd(1'b0, OP_DATA_LO, SEL_PC, word[NB_HALF-1:0]));
			load_frame(make_cmd(1'b0, OP_DATA_HI, SEL_PC, word[NB_WORD-1:NB_HALF]));
			load_frame(make_cmd(1'b0, OP_ADDR, SEL_PC, NB_HALF'(k)));
			load_frame(make_cmd(1'b1, OP_NONE, SEL_PC, '0)); // write frame
			model_mem[k]   = word;
			model_valid[k] = 1'b1;
		end
	endtask

	task automatic run_fetch();
		logic [NB_WORD-1:0]       prev_pc;
		logic [NB_WORD-1:0]       prev_instr;
		logic [NB_WORD-1:0]       exp_pc;
		logic [RAM_DEPTH_LOG-1:0] idx;
		int                       wait_cnt;
		@(posedge clk);
		in_use <= 1'b0;
		@(negedge clk);
		prev_pc    = latch_pc;
		prev_instr = latch_instr;
		exp_pc     = '0; // fetch starts at address zero
		for (int k = 0; k < RUN_CHECKS; k++) begin
			wait_cnt = 0;
			do begin
				@(negedge clk);
				wait_cnt++;
				if (wait_cnt > WAIT_LIMIT) begin
					fail_run("IF/ID latch did not update while running");
				end
			end while (latch_pc === prev_pc && latch_instr === prev_instr);
			check_value("run fetch pc", exp_pc, latch_pc);
			idx = latch_pc[RAM_DEPTH_LOG+1:2];
			if (model_valid[idx]) begin // unloaded words read undefined
				check_value("run fetch instr", model_mem[idx], latch_instr);
			end
			prev_pc    = latch_pc;
			prev_instr = latch_instr;
			exp_pc     = exp_pc + 32'd4;
		end
	endtask

	task automatic halt_pc();
		logic [NB_WORD-1:0] held_pc;
		@(posedge clk);
		in_use <= 1'b1;
		@(negedge clk);
		held_pc = pc; // last step already taken
		repeat (HALT_CYCLES) begin
			@(negedge clk);
			check_value("halt pc", held_pc, pc);
		end
	endtask

	task automatic readback();
		logic [1:0]         sel_codes [4];
		logic [NB_WORD-1:0] expected  [4];
		logic [NB_WORD-1:0] reply;
		sel_codes[0] = SEL_PC;
		sel_codes[1] = SEL_LATCH_PC;
		sel_codes[2] = SEL_LATCH_INSTR;
		sel_codes[3] = 2'b11; // unused code
		@(negedge clk);
		expected[0] = pc;
		expected[1] = latch_pc;
		expected[2] = latch_instr;
		expected[3] = '0;
		for (int k = 0; k < 4; k++) begin
			spi_frame(make_cmd(1'b0, OP_NONE, sel_codes[k], '0), reply);
			spi_frame(make_cmd(1'b0, OP_NONE, SEL_PC, '0), reply); // carries the answer
			check_value("readback", expected[k], reply);
		end
	endtask

	initial begin
		in_use = 1'b1; // start halted
		sclk   = 1'b0;
		cs_n   = 1'b1;
		mosi   = 1'b0;
		for (int a = 0; a < RAM_DEPTH; a++) begin
			model_valid[a] = 1'b0;
		end
		void'($urandom(SEED));
		reset_state();
		debug_load();
		run_fetch();
		halt_pc();
		readback();
		repeat (4) @(posedge clk);
		if (dut0.props0.err_cnt == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			fail_run("assertions fired during the run");
		end
	end

endmodule

`default_nettype wire

//--- sources.f
rtl/dbg_pkg.sv
rtl/ram_port_if.sv
rtl/spi_slave.sv
rtl/debug_fetch_if.sv
rtl/instr_ram.sv
rtl/fetch_stage.sv
rtl/debug_fetch_top.sv
tests/tb_clock.sv
tests/debug_fetch_props.sv
tests/tb_debug_fetch.sv

//--- Bender.yml
package:
  name: debug_fetch

sources:
  - files:
      - rtl/dbg_pkg.sv
      - rtl/ram_port_if.sv
      - rtl/spi_slave.sv
      - rtl/debug_fetch_if.sv
      - rtl/instr_ram.sv
      - rtl/fetch_stage.sv
      - rtl/debug_fetch_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/debug_fetch_props.sv
      - tests/tb_debug_fetch.sv
